//--- bench/dbg_tb.sv
// Testbench for the debug status block, run at the default top parameters.
// Host fields and random addresses come from a 16-bit Fibonacci LFSR, seed 21.
// Concurrent assertions compare st_dout, snd_mode and vu_peak with a model of
// the address map. Counter values are only read once they are stable.
`timescale 1ns/1ns

module dbg_tb;

    import dbg_pkg::*;
    import snd_pkg::*;

    localparam int ms_ticks  = 200;
    localparam int peak_hold = 8;

    logic        clk = 1'b0;
    logic        rst;
    logic        lvbl, sample;
    host_in_t    host;
    stereo_t     snd;
    logic [7:0]  snd_vol;
    logic [5:0]  snd_en, snd_vu;
    logic [3:0]  ba_rdy;
    st_addr_t    st_addr;
    logic [7:0]  st_dout;
    logic        snd_mode, vu_peak;

    int          exp_frame;        // qualified lvbl rises so far
    logic [7:0]  exp_srate, exp_vu;
    logic [7:0]  exp_bank [4];
    int          peak_left;        // enables left in the clip hold
    logic [1:0]  sample_mode;      // 0 idle, 1 every 8 clocks, 2 every other clock
    logic [15:0] lfsr = 16'd21;
    int          win;              // srate window position
    logic [19:0] frame_bcd;
    logic [7:0]  model_byte, model_byte_q;
    logic        model_mode, model_mode_q;

    dbg_top #(.ms_ticks(ms_ticks), .vu_decay(4), .peak_hold(peak_hold)) u_dbg_top (
        .clk(clk), .rst(rst), .lvbl(lvbl), .host(host), .sample(sample), .snd(snd),
        .snd_vol(snd_vol), .snd_en(snd_en), .snd_vu(snd_vu), .ba_rdy(ba_rdy),
        .st_addr(st_addr), .st_dout(st_dout), .snd_mode(snd_mode), .vu_peak(vu_peak)
    );

    always #20 clk = ~clk;

    function automatic logic [19:0] to_bcd(input int n);
        logic [19:0] b;
        int          v;
        v = n;
        for (int i = 0; i < 5; i++) begin
            b[4*i+:4] = 4'(v % 10);
            v = v / 10;
        end
        return b;
    endfunction

    function automatic logic [95:0] rand_bits(input int n);
        logic [95:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[94:0], lfsr[0]};
        end
        return r;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win <= 0;
        end else if (win == ms_ticks - 1) begin
            win <= 0; // window closes, srate takes the count
        end else begin
            win <= win + 1;
        end
    end

    // expected byte and mode for the address currently on st_addr
    always_comb begin
        frame_bcd  = to_bcd(exp_frame);
        model_mode = (st_addr[7:6] == area_snd) && (st_addr[5:4] != snd_sub_host);
        model_byte = 8'd0;
        case (st_addr[7:6])
            area_frame: case (st_addr[1:0])
                2'd0:    model_byte = frame_bcd[15:8];
                2'd1:    model_byte = frame_bcd[7:0];
                2'd2:    model_byte = {4'd0, frame_bcd[19:16]};
                default: model_byte = 8'd0;
            endcase
            area_snd: case (st_addr[5:4])
                snd_sub_vu:  model_byte = exp_vu;
                snd_sub_vol: model_byte = snd_vol;
                snd_sub_meter: begin
                    if (st_addr[1:0] == 2'd0) model_byte = {2'd0, snd_vu & snd_en};
                    if (st_addr[1:0] == 2'd1) model_byte = {2'd0, snd_en};
                    if (st_addr[1:0] == 2'd2) model_byte = exp_srate;
                end
                default: begin
                    if (st_addr[3:2] == 2'd0) begin
                        model_byte = {3'd0, host.ioctl_ram, 2'd0, host.ioctl_cart, host.ioctl_rom};
                    end else if (st_addr[3:2] == 2'd1) begin
                        if (st_addr[1:0] == 2'd0) model_byte = host.dipsw[7:0];
                        if (st_addr[1:0] == 2'd1) model_byte = host.dipsw[15:8];
                        if (st_addr[1:0] == 2'd2) model_byte = host.dipsw[23:16];
                    end
                end
            endcase
            area_bank: model_byte = exp_bank[st_addr[1:0]];
            default: case (st_addr[5:4])
                2'd0:    model_byte = {host.core_mod[3:0], host.dial_x,
                                       host.game_led, host.dip_flip};
                2'd1:    model_byte = host.mouse_dx[8:1];
                2'd2:    model_byte = host.mouse_dy[8:1];
                default: model_byte = host.mouse_f;
            endcase
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            model_byte_q <= 8'd0;
            model_mode_q <= 1'b0;
        end else begin
            model_byte_q <= model_byte; // one cycle of read latency
            model_mode_q <= model_mode;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("[ERROR] %0t ns: %s", $time, what));
    endtask

    a_reset_clear: assert property (@(posedge clk)
        $fell(rst) |-> st_dout == 8'd0 && !snd_mode && !vu_peak)
        else report_mismatch("outputs not cleared by reset");
    a_dout: assert property (@(posedge clk) disable iff (rst) st_dout == model_byte_q)
        else report_mismatch($sformatf("st_dout %h, expected %h", $sampled(st_dout),
                                       $sampled(model_byte_q)));
    a_mode: assert property (@(posedge clk) disable iff (rst) snd_mode == model_mode_q)
        else report_mismatch($sformatf("snd_mode %b, expected %b", $sampled(snd_mode),
                                       $sampled(model_mode_q)));
    a_peak: assert property (@(posedge clk) disable iff (rst) vu_peak == (peak_left != 0))
        else report_mismatch($sformatf("vu_peak %b with %0d hold enables left",
                                       $sampled(vu_peak), $sampled(peak_left)));

    task automatic next_cycle();
        @(posedge clk);
        #1;
        case (sample_mode)
            2'd1:    sample = win[2:0] == 3'd3; // never on the window's last clock
            2'd2:    sample = ~win[0]; // 100 rises per window, none on its last clock
            default: ;
        endcase
    endtask

    task automatic randomize_inputs();
        logic [95:0] r;
        r       = rand_bits($bits(host_in_t));
        host    = r[$bits(host_in_t)-1:0];
        r       = rand_bits(20);
        snd_vol = r[7:0];
        snd_en  = r[13:8];
        snd_vu  = r[19:14];
    endtask

    task automatic read_addr(input logic [7:0] a);
        st_addr = a;
        next_cycle();
        next_cycle();
        st_addr = 8'hc0;
    endtask

    task automatic pulse_lvbl();
        lvbl = 1'b1;
        next_cycle();
        next_cycle();
        lvbl = 1'b0;
        next_cycle();
        next_cycle();
    endtask

    task automatic pulse_bank(input int b, input int n);
        for (int i = 0; i < n; i++) begin
            ba_rdy = 4'(1 << b);
            next_cycle();
            ba_rdy = 4'd0;
            next_cycle();
        end
    endtask

    task automatic wait_window_end();
        int n;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (win != 0 && n < 2 * ms_ticks);
        if (win != 0) abort_run("timeout waiting for the srate window to close");
    endtask

    task automatic send_sample(input logic signed [15:0] l, input logic signed [15:0] r);
        int ml, mr;
        ml = (l < 0) ? -int'(l) : int'(l);
        mr = (r < 0) ? -int'(r) : int'(r);
        snd.l  = l;
        snd.r  = r;
        sample = 1'b1;
        next_cycle();
        sample = 1'b0;
        if (ml >= 32767 || mr >= 32767) begin
            peak_left = peak_hold; // clip restarts the hold
        end else if (peak_left > 0) begin
            peak_left--;
        end
        next_cycle();
    endtask

    task automatic wait_peak_low();
        int n;
        n = 0;
        while (vu_peak && n < 4 * peak_hold) begin
            next_cycle();
            n++;
        end
        if (vu_peak) abort_run("timeout, vu_peak still high after the hold period");
    endtask

    initial begin
        rst = 1'b1;
        lvbl = 1'b0;
        sample = 1'b0;
        sample_mode = 2'd0;
        host = '0;
        snd = '0;
        snd_vol = 8'd0;
        snd_en = 6'd0;
        snd_vu = 6'd0;
        ba_rdy = 4'd0;
        st_addr = 8'hc0;
        exp_frame = 0;
        exp_srate = 8'd0;
        exp_vu = 8'd0;
        peak_left = 0;
        for (int b = 0; b < 4; b++) exp_bank[b] = 8'd0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // every address once, fresh host inputs each time
        for (int a = 0; a < 256; a++) begin
            randomize_inputs();
            st_addr = 8'(a);
            next_cycle();
        end
        st_addr = 8'hc0;

        host.dip_pause = 1'b1;
        repeat (13) pulse_lvbl();
        exp_frame = 13;
        for (int a = 0; a < 4; a++) read_addr(8'(a));
        host.dip_pause = 1'b0; // frozen count
        repeat (5) pulse_lvbl();
        for (int a = 0; a < 4; a++) read_addr(8'(a));

        sample_mode = 2'd1;
        wait_window_end(); // first window is partial
        wait_window_end();
        exp_srate = 8'h25;
        read_addr(8'h52);
        sample_mode = 2'd2;
        wait_window_end();
        wait_window_end();
        exp_srate = 8'h99;
        read_addr(8'h52);
        sample_mode = 2'd0;
        sample = 1'b0;

        pulse_lvbl(); // fall starts a clean frame
        pulse_bank(0, 3);
        pulse_bank(1, 0);
        pulse_bank(2, 5);
        pulse_bank(3, 7);
        pulse_lvbl();
        exp_bank[0] = 8'd3;
        exp_bank[1] = 8'd0;
        exp_bank[2] = 8'd5;
        exp_bank[3] = 8'd7;
        for (int b = 0; b < 4; b++) read_addr(8'h80 + 8'(b));

        send_sample(16'sh0400, 16'sh0000);
        exp_vu = 8'd10; // leading one at bit 10
        read_addr(8'h40);
        send_sample(16'sh8000, 16'sh0000);
        repeat (peak_hold) send_sample(16'sh0000, 16'sh0000);
        wait_peak_low();

        next_cycle();
        next_cycle();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- build.f
logic/dbg_pkg.sv
logic/snd_pkg.sv
logic/bcd_cnt.sv
logic/bank_stats.sv
logic/vu_meter.sv
logic/sys_info.sv
logic/dbg_top.sv
bench/dbg_tb.sv

//--- logic/bank_stats.sv
// Memory bank ready statistics, one 8-bit count per bank and frame.
// A bank's count goes up on every clock its rdy bit is high, so rdy is
// expected as one-cycle pulses. Counts saturate at 255.
// The falling edge of lvbl latches the counts and starts a new frame.
`timescale 1ns/1ns

module bank_stats (
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] rdy,
    input  logic       lvbl,
    input  logic [1:0] sel,
    output logic [7:0] dout
);

    logic [3:0][7:0] run_cnt;  // counting during the frame
    logic [3:0][7:0] lat_cnt;  // last full frame
    logic            lvbl_l;
    logic            lvbl_fall;

    assign lvbl_fall = lvbl_l & ~lvbl;
    assign dout      = lat_cnt[sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
        end
    end

    for (genvar b = 0; b < 4; b++) begin : g_bank
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                run_cnt[b] <= '0;
                lat_cnt[b] <= '0;
            end else if (lvbl_fall) begin
                lat_cnt[b] <= run_cnt[b];
                run_cnt[b] <= {7'd0, rdy[b]}; // a pulse on the edge belongs to the new frame
            end else if (rdy[b] && run_cnt[b] != 8'hff) begin
                run_cnt[b] <= run_cnt[b] + 8'd1;
            end
        end

        // between two lvbl falls a count only climbs or holds
        a_no_wrap: assert property (
            @(posedge clk) disable iff (rst)
            !lvbl_fall |=> run_cnt[b] >= $past(run_cnt[b])
        ) else $error("bank_stats counter %0d wrapped inside a frame", b);
    end

endmodule

//--- logic/bcd_cnt.sv
// Multi-digit BCD up-counter.
// clr wins over up. At all nines the count wraps to zero when wrap is set,
// otherwise it holds there until cleared.
// Assumes the count only ever gets here through this logic, never loaded.
`timescale 1ns/1ns

module bcd_cnt #(
    parameter int digits = 2,
    parameter bit wrap   = 1'b1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clr,
    input  logic                  up,
    output logic [4*digits-1:0]   cnt
);

    logic [digits:0]     carry;  // carry[i] goes into digit i
    logic [4*digits-1:0] nxt;

    always_comb begin
        carry[0] = 1'b1;
        for (int i = 0; i < digits; i++) begin
            if (carry[i]) begin
                nxt[4*i+:4] = (cnt[4*i+:4] == 4'd9) ? 4'd0 : cnt[4*i+:4] + 4'd1;
            end else begin
                nxt[4*i+:4] = cnt[4*i+:4];
            end
            carry[i+1] = carry[i] & (cnt[4*i+:4] == 4'd9);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (clr) begin
            cnt <= '0;
        end else if (up) begin
            if (!carry[digits] || wrap) begin
                cnt <= nxt; // all nines rolls to zeros through nxt
            end
        end
    end

    // every digit stays a legal BCD value
    for (genvar g = 0; g < digits; g++) begin : g_digit_chk
        a_bcd_digit: assert property (
            @(posedge clk) disable iff (rst) cnt[4*g+:4] <= 4'd9
        ) else $error("bcd_cnt digit %0d out of range", g);
    end

endmodule

//--- logic/dbg_pkg.sv
// Debug status address map and packed host inputs.
// The address is 8 bits. Bits 7:6 select the area and bits 5:4 select the
// sub-field inside the sound and host areas.
// The host inputs are plain levels, already synchronous to clk.
package dbg_pkg;

    typedef logic [7:0] st_addr_t;

    // areas, st_addr[7:6]
    localparam logic [1:0] area_frame = 2'd0;
    localparam logic [1:0] area_snd   = 2'd1;
    localparam logic [1:0] area_bank  = 2'd2;
    localparam logic [1:0] area_host  = 2'd3;

    // sound sub-fields, st_addr[5:4]
    localparam logic [1:0] snd_sub_vu    = 2'd0;
    localparam logic [1:0] snd_sub_meter = 2'd1; // vu/en flags and srate
    localparam logic [1:0] snd_sub_vol   = 2'd2;
    localparam logic [1:0] snd_sub_host  = 2'd3; // ioctl and dips, no snd_mode

    typedef struct packed {
        logic        dip_pause;  // high lets the frame counter run
        logic        dip_flip;
        logic        game_led;
        logic [ 6:0] core_mod;
        logic [ 1:0] dial_x;
        logic [23:0] dipsw;
        logic        ioctl_ram;
        logic        ioctl_rom;
        logic        ioctl_cart;
        logic [ 8:0] mouse_dx;
        logic [ 8:0] mouse_dy;
        logic [ 7:0] mouse_f;
    } host_in_t;

endpackage

//--- logic/dbg_top.sv
// Top of the debug status block.
// Sets the measurement window and meter timing for the target clock.
// ms_ticks is clocks per srate window, vu_decay and peak_hold count
// sample enables. All inputs must already be in the clk domain.
`timescale 1ns/1ns

module dbg_top #(
    parameter int ms_ticks  = 200,
    parameter int vu_decay  = 4,
    parameter int peak_hold = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              lvbl,
    input  dbg_pkg::host_in_t host,
    input  logic              sample,
    input  snd_pkg::stereo_t  snd,
    input  logic [7:0]        snd_vol,
    input  logic [5:0]        snd_en,
    input  logic [5:0]        snd_vu,
    input  logic [3:0]        ba_rdy,
    input  dbg_pkg::st_addr_t st_addr,
    output logic [7:0]        st_dout,
    output logic              snd_mode,
    output logic              vu_peak
);

    sys_info #(
        .ms_ticks  (ms_ticks),
        .vu_decay  (vu_decay),
        .peak_hold (peak_hold)
    ) u_info (
        .clk      (clk),
        .rst      (rst),
        .lvbl     (lvbl),
        .host     (host),
        .sample   (sample),
        .snd      (snd),
        .snd_vol  (snd_vol),
        .snd_en   (snd_en),
        .snd_vu   (snd_vu),
        .ba_rdy   (ba_rdy),
        .st_addr  (st_addr),
        .st_dout  (st_dout),
        .snd_mode (snd_mode),
        .vu_peak  (vu_peak)
    );

endmodule

//--- logic/snd_pkg.sv
// Sound side types for the debug block.
// Samples are signed 16-bit two's complement, one word per channel.
// Magnitudes are unsigned 16 bits, so a full negative sample reads 32768.
package snd_pkg;

    typedef struct packed {
        logic signed [15:0] l;
        logic signed [15:0] r;
    } stereo_t;

    typedef logic [15:0] vu_mag_t; // unsigned sample magnitude

    // at or above this the sample counts as clipped
    localparam vu_mag_t vu_full = 16'd32767;

endpackage

//--- logic/sys_info.sv
// Debug status read-out. st_addr selects a byte, st_dout returns it on
// the next clock. No handshake, any address can be read at any time.
// frame counter: 5 BCD digits, counts lvbl rises while dip_pause is high.
// srate: sample strobes per window of ms_ticks clocks, BCD, tops out at 99.
// sample is a level; its rising edge counts and the level itself is the
// VU meter enable.
`timescale 1ns/1ns

module sys_info #(
    parameter int ms_ticks  = 200,
    parameter int vu_decay  = 4,
    parameter int peak_hold = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              lvbl,
    input  dbg_pkg::host_in_t host,
    input  logic              sample,
    input  snd_pkg::stereo_t  snd,
    input  logic [7:0]        snd_vol,
    input  logic [5:0]        snd_en,
    input  logic [5:0]        snd_vu,
    input  logic [3:0]        ba_rdy,
    input  dbg_pkg::st_addr_t st_addr,
    output logic [7:0]        st_dout,
    output logic              snd_mode,
    output logic              vu_peak
);

    import dbg_pkg::*;

    localparam int fw = $clog2(ms_ticks + 1);

    logic          lvbl_l, sample_l;
    logic          frame_up, sample_up, sample_clr;
    logic [19:0]   frame_bcd;
    logic [7:0]    scnt;      // samples so far in this window
    logic [7:0]    srate;
    logic [fw-1:0] freq_cnt;
    logic [7:0]    bank_cnt;
    logic [7:0]    vu_lvl;

    assign frame_up   = lvbl & ~lvbl_l & host.dip_pause;
    assign sample_up  = sample & ~sample_l;
    assign sample_clr = freq_cnt == fw'(ms_ticks - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l   <= 1'b0;
            sample_l <= 1'b0;
            freq_cnt <= '0;
            srate    <= '0;
        end else begin
            lvbl_l   <= lvbl;
            sample_l <= sample;
            if (sample_clr) begin
                freq_cnt <= '0;
                srate    <= scnt; // once per window
            end else begin
                freq_cnt <= freq_cnt + 1'b1;
            end
        end
    end

    // address decode, one cycle of latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st_dout  <= '0;
            snd_mode <= 1'b0;
        end else begin
            snd_mode <= 1'b0;
            st_dout  <= '0;
            case (st_addr[7:6])
                area_frame: case (st_addr[1:0])
                    2'd0:    st_dout <= frame_bcd[15:8];
                    2'd1:    st_dout <= frame_bcd[7:0];
                    2'd2:    st_dout <= {4'd0, frame_bcd[19:16]};
                    default: st_dout <= '0;
                endcase
                area_snd: begin
                    snd_mode <= 1'b1;
                    case (st_addr[5:4])
                        snd_sub_vu:    st_dout <= vu_lvl;
                        snd_sub_meter: case (st_addr[1:0])
                            2'd0:    st_dout <= {2'd0, snd_vu & snd_en};
                            2'd1:    st_dout <= {2'd0, snd_en};
                            2'd2:    st_dout <= srate;
                            default: st_dout <= '0;
                        endcase
                        snd_sub_vol:   st_dout <= snd_vol;
                        snd_sub_host: begin
                            snd_mode <= 1'b0; // host data lives here too
                            if (st_addr[3:2] == 2'd0) begin
                                st_dout <= {3'd0, host.ioctl_ram, 2'd0,
                                            host.ioctl_cart, host.ioctl_rom};
                            end else if (st_addr[3:2] == 2'd1) begin
                                case (st_addr[1:0])
                                    2'd0:    st_dout <= host.dipsw[0+:8];
                                    2'd1:    st_dout <= host.dipsw[8+:8];
                                    2'd2:    st_dout <= host.dipsw[16+:8];
                                    default: st_dout <= '0;
                                endcase
                            end
                        end
                    endcase
                end
                area_bank: st_dout <= bank_cnt;
                area_host: case (st_addr[5:4])
                    2'd0: st_dout <= {host.core_mod[3:0], host.dial_x,
                                      host.game_led, host.dip_flip};
                    2'd1: st_dout <= host.mouse_dx[8:1];
                    2'd2: st_dout <= host.mouse_dy[8:1];
                    2'd3: st_dout <= host.mouse_f;
                endcase
            endcase
        end
    end

    bcd_cnt #(.digits(5), .wrap(1'b1)) u_frame_cnt (
        .clk (clk),
        .rst (rst),
        .clr (1'b0),
        .up  (frame_up),
        .cnt (frame_bcd)
    );

    bcd_cnt #(.digits(2), .wrap(1'b0)) u_sample_cnt (
        .clk (clk),
        .rst (rst),
        .clr (sample_clr),
        .up  (sample_up),
        .cnt (scnt)
    );

    bank_stats u_bank (
        .clk  (clk),
        .rst  (rst),
        .rdy  (ba_rdy),
        .lvbl (lvbl),
        .sel  (st_addr[1:0]),
        .dout (bank_cnt)
    );

    vu_meter #(.vu_decay(vu_decay), .peak_hold(peak_hold)) u_vu (
        .clk  (clk),
        .rst  (rst),
        .cen  (sample),
        .snd  (snd),
        .vu   (vu_lvl),
        .peak (vu_peak)
    );

    a_snd_mode: assert property (
        @(posedge clk) disable iff (rst)
        (st_addr[7:6] == area_snd && st_addr[5:4] != snd_sub_host) |=> snd_mode
    ) else $error("snd_mode missing after a sound address");

endmodule

//--- logic/vu_meter.sv
// Stereo level meter in 6 dB steps.
// The level is the leading-one position of the larger channel magnitude,
// 0 to 15, so silence and a magnitude of one both read 0.
// Rises are immediate, falls are one step every vu_decay enables.
// peak stays up for peak_hold enables after the last clipped sample.
`timescale 1ns/1ns

module vu_meter #(
    parameter int vu_decay  = 4,
    parameter int peak_hold = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  snd_pkg::stereo_t  snd,
    output logic [7:0]        vu,
    output logic              peak
);

    import snd_pkg::*;

    localparam int dw = $clog2(vu_decay + 1);
    localparam int hw = $clog2(peak_hold + 1);

    vu_mag_t         mag_l, mag_r, mag;
    logic [3:0]      pos;      // leading one of mag
    logic [3:0]      level;
    logic [dw-1:0]   decay_cnt;
    logic [hw-1:0]   hold_cnt;

    always_comb begin
        mag_l = snd.l[15] ? vu_mag_t'(~snd.l + 16'd1) : vu_mag_t'(snd.l);
        mag_r = snd.r[15] ? vu_mag_t'(~snd.r + 16'd1) : vu_mag_t'(snd.r);
        mag   = (mag_l > mag_r) ? mag_l : mag_r;
        pos   = 4'd0;
        for (int i = 0; i < 16; i++) begin
            if (mag[i]) pos = 4'(i); // highest set bit wins
        end
    end

    assign vu   = {4'd0, level};
    assign peak = hold_cnt != '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level     <= '0;
            decay_cnt <= '0;
            hold_cnt  <= '0;
        end else if (cen) begin
            if (pos >= level) begin
                level     <= pos;
                decay_cnt <= '0;
            end else if (decay_cnt == dw'(vu_decay - 1)) begin
                level     <= level - 4'd1;
                decay_cnt <= '0;
            end else begin
                decay_cnt <= decay_cnt + 1'b1;
            end
            if (mag >= vu_full) begin
                hold_cnt <= hw'(peak_hold);
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Compile the debug status block with Verilator and run the testbench.
# The exit status is that of the simulation.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module dbg_tb -f build.f -o dbg_sim &&
./obj_dir/dbg_sim ||
exit 1
